// ==== src.f ====
hw/rcc_pkg.sv
hw/clk_gate_cell.sv
hw/sync_reset_clk_gate.sv
hw/per_ker_clk_rst_control.sv
hw/rcc_per_subsystem.sv
test/rcc_per_chk.sv
test/tb_rcc_per_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the RCC peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f src.f \
  --top-module tb_rcc_per_subsystem \
  -o sim_rcc
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/sim_rcc
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0

// ==== test/tb_rcc_per_subsystem.sv ====
// RCC peripheral subsystem testbench

`timescale 1ns/1ps

module tb_rcc_per_subsystem;

  logic       bus_clk, arst_n, d1_rst_n, d2_rst_n;
  logic [3:0] ker_src_clks;
  logic       uart_sft_rst_n, spi_sft_rst_n, lptim_sft_rst_n;
  logic       uart_c1_en, uart_c1_lpen, uart_c2_en, uart_c2_lpen;
  logic       spi_c1_en, spi_c1_lpen, spi_c2_en, spi_c2_lpen;
  logic       lptim_c1_en, lptim_c1_lpen, lptim_c2_en, lptim_c2_lpen, lptim_amen;
  logic [1:0] uart_ker_sel, spi_ker_sel, lptim_ker_sel;
  logic       uart_ker_req, spi_ker_req, lptim_ker_req;
  logic       c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep, d3_deepsleep;
  logic       arcg_on, testmode, test_rst_n;
  logic       uart_bus_clk, uart_rst_n, uart_csi_req, uart_hsi_req;
  logic       spi_bus_clk, spi_rst_n, spi_csi_req, spi_hsi_req;
  logic       lptim_bus_clk, lptim_rst_n, lptim_csi_req, lptim_hsi_req;
  logic [3:0] uart_ker_clks, spi_ker_clks, lptim_ker_clks;

  int          bus_edges[3];
  int          ker_edges[3];
  int          bus_win[3];
  int          ker_win[3];
  int          cycles;

  rcc_per_subsystem i_dut (.*);

  // ==========================================================================
  // clocks, edge counters, timeout
  // ==========================================================================

  initial bus_clk = 1'b0;
  always #4 bus_clk = ~bus_clk;
  initial ker_src_clks = '0;
  always #5 ker_src_clks[rcc_pkg::HSI_IDX] = ~ker_src_clks[rcc_pkg::HSI_IDX];
  always #6 ker_src_clks[rcc_pkg::CSI_IDX] = ~ker_src_clks[rcc_pkg::CSI_IDX];
  always #15 ker_src_clks[rcc_pkg::LSE_IDX] = ~ker_src_clks[rcc_pkg::LSE_IDX];
  always #20 ker_src_clks[rcc_pkg::LSI_IDX] = ~ker_src_clks[rcc_pkg::LSI_IDX];

  always @(posedge uart_bus_clk) bus_edges[0]++;
  always @(posedge spi_bus_clk) bus_edges[1]++;
  always @(posedge lptim_bus_clk) bus_edges[2]++;
  // uart csi, lptim lse, spi hsi
  always @(posedge uart_ker_clks[rcc_pkg::CSI_IDX]) ker_edges[0]++;
  always @(posedge lptim_ker_clks[rcc_pkg::LSE_IDX]) ker_edges[1]++;
  always @(posedge spi_ker_clks[rcc_pkg::HSI_IDX]) ker_edges[2]++;

  always @(posedge bus_clk) begin
    cycles++;
    if (cycles >= 2000) begin
      $display("timeout: run did not finish within 2000 bus cycles");
      $display("Test failed");
      $fatal(1);
    end
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  // one cpu enable term with lpen only where the slice supports it
  function automatic bit cpu_term(bit en, bit lpen, bit slp, bit deep, bit has_lpen);
    return en && (has_lpen ? (!slp || lpen) : 1'b1) && !deep;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic step();
    @(posedge bus_clk);
    #1;
  endtask

  // let the gates settle and count edges over 16 bus cycles
  task automatic measure_window();
    int b0[3];
    int k0[3];
    repeat (6) step();
    b0 = bus_edges;
    k0 = ker_edges;
    repeat (16) step();
    for (int i = 0; i < 3; i++) begin
      bus_win[i] = bus_edges[i] - b0[i];
      ker_win[i] = ker_edges[i] - k0[i];
    end
  endtask

  task automatic check_val(input string test, input int exp, input int act);
    assert (exp == act)
      else report_error($sformatf("[ERROR] %s: expected %0d actual %0d", test, exp, act));
  endtask

  task automatic check_act(input string test, input bit on, input int min, input int n);
    if (on) begin
      assert (n >= min)
        else report_error($sformatf("[ERROR] %s: expected >= %0d actual %0d", test, min, n));
    end else begin
      check_val(test, 0, n);
    end
  endtask

  task automatic set_cpu(input logic [7:0] v);
    {c1_deepsleep, c1_sleep, uart_c1_lpen, uart_c1_en} = v[3:0];
    {c2_deepsleep, c2_sleep, uart_c2_lpen, uart_c2_en} = v[7:4];
    {spi_c1_lpen, spi_c1_en, lptim_c1_lpen, lptim_c1_en} = {2{v[1:0]}};
    {spi_c2_lpen, spi_c2_en, lptim_c2_lpen, lptim_c2_en} = {2{v[5:4]}};
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================

  task automatic reset_test();
    logic [5:0] v;
    // bits are lptim_sft, spi_sft, uart_sft, d2, d1, arst
    for (int i = 0; i < 7; i++) begin
      v = (i < 6) ? ~(6'b1 << i) : 6'b111001;
      step();
      {lptim_sft_rst_n, spi_sft_rst_n, uart_sft_rst_n, d2_rst_n, d1_rst_n, arst_n} = v;
      @(negedge bus_clk);
      check_val("reset uart", v[0] & v[1] & v[3], uart_rst_n);
      check_val("reset spi", v[0] & v[2] & v[4], spi_rst_n);
      check_val("reset lptim", v[0] & v[5], lptim_rst_n);
    end
    step();
    {lptim_sft_rst_n, spi_sft_rst_n, uart_sft_rst_n, d2_rst_n, d1_rst_n, arst_n} = '1;
  endtask

  task automatic release_test();
    int prev;
    repeat (4) step();
    uart_sft_rst_n = 1'b0;
    repeat (2) step();
    uart_sft_rst_n = 1'b1;
    for (int k = 1; k <= rcc_pkg::ARCG_DELAY + 4; k++) begin
      prev = bus_edges[0];
      step();
      check_val("release pulse", k > rcc_pkg::ARCG_DELAY, bus_edges[0] - prev);
    end
    arcg_on = 1'b0;
    measure_window();
    check_act("arcg off uart", 1'b0, 14, bus_win[0]);
    arcg_on = 1'b1;
  endtask

  task automatic cpu_test();
    logic [7:0] cpu_cases [10];
    logic [7:0] v;
    // bit order is c2 deep sleep lpen en then c1 in the same order
    cpu_cases = '{8'h00, 8'h04, 8'h06, 8'h05, 8'h09, 8'h18, 8'h58, 8'h78, 8'h98, 8'h01};
    for (int n = 0; n < 10; n++) begin
      v = cpu_cases[n];
      set_cpu(v);
      measure_window();
      check_act("cpu uart", cpu_term(1'b1, v[1], v[2], v[3], 1'b1) ||
                cpu_term(v[4], v[5], v[6], v[7], 1'b1), 14, bus_win[0]);
      check_act("cpu spi", cpu_term(v[0], v[1], v[2], v[3], 1'b0) ||
                cpu_term(v[4], v[5], v[6], v[7], 1'b0), 14, bus_win[1]);
      check_act("cpu lptim", cpu_term(v[0], v[1], v[2], v[3], 1'b0) ||
                cpu_term(v[4], v[5], v[6], v[7], 1'b0), 14, bus_win[2]);
    end
    set_cpu(8'h00);
  endtask

  task automatic amen_test();
    for (int n = 0; n < 4; n++) begin
      {lptim_amen, d3_deepsleep} = n[1:0];
      measure_window();
      check_act("amen lptim", lptim_amen && !d3_deepsleep, 14, bus_win[2]);
    end
    {lptim_amen, d3_deepsleep} = 2'b00;
  endtask

  task automatic kernel_test();
    for (int n = 0; n < 8; n++) begin
      step();
      {uart_ker_sel, uart_ker_req} = n[2:0];
      {spi_ker_sel, spi_ker_req} = n[2:0];
      {lptim_ker_sel, lptim_ker_req} = n[2:0];
      @(negedge bus_clk);
      check_val("uart csi_req", (n[2:1] == rcc_pkg::CSI_IDX) && n[0], uart_csi_req);
      check_val("uart hsi_req", (n[2:1] == rcc_pkg::HSI_IDX) && n[0], uart_hsi_req);
      check_val("spi csi_req", (n[2:1] == rcc_pkg::CSI_IDX) && n[0], spi_csi_req);
      check_val("spi hsi_req", (n[2:1] == rcc_pkg::HSI_IDX) && n[0], spi_hsi_req);
      check_val("lptim reqs", 0, {lptim_csi_req, lptim_hsi_req});
    end
    // lptim bus off so only the low speed selection runs the kernel clock
    step();
    lptim_ker_sel = rcc_pkg::LSE_IDX;
    measure_window();
    check_act("lse bus off", 1'b0, 14, bus_win[2]);
    check_act("lse kernel", 1'b1, 1, ker_win[1]);
    lptim_ker_sel = rcc_pkg::HSI_IDX;
    measure_window();
    check_act("hsi sel lptim", 1'b0, 1, ker_win[1]);
    // uart bus stopped by deep sleep so csi runs on the request alone
    c1_deepsleep = 1'b1;
    uart_ker_sel = rcc_pkg::CSI_IDX;
    for (int r = 0; r < 2; r++) begin
      uart_ker_req = r[0];
      measure_window();
      check_act("csi kernel", r[0], 1, ker_win[0]);
    end
    uart_ker_req = 1'b0;
  endtask

  task automatic testmode_test();
    testmode = 1'b1;
    measure_window();
    for (int i = 0; i < 3; i++) begin
      check_act("testmode bus", 1'b1, 14, bus_win[i]);
      check_act("testmode kernel", 1'b1, 1, ker_win[i]);
    end
    uart_sft_rst_n = 1'b0;
    @(negedge bus_clk);
    check_val("testmode rst high", 3'b111, {uart_rst_n, spi_rst_n, lptim_rst_n});
    step();
    test_rst_n = 1'b0;
    @(negedge bus_clk);
    check_val("testmode rst low", 3'b000, {uart_rst_n, spi_rst_n, lptim_rst_n});
    step();
    {testmode, test_rst_n, uart_sft_rst_n, c1_deepsleep} = 4'b0110;
    repeat (4) step();
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial begin
    cycles = 0;
    {arst_n, d1_rst_n, d2_rst_n} = 3'b011;
    {uart_sft_rst_n, spi_sft_rst_n, lptim_sft_rst_n} = '1;
    set_cpu(8'h00);
    {lptim_amen, c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep, d3_deepsleep} = '0;
    {uart_ker_sel, spi_ker_sel, lptim_ker_sel} = '0;
    {uart_ker_req, spi_ker_req, lptim_ker_req} = '0;
    {arcg_on, testmode, test_rst_n} = 3'b101;
    repeat (4) @(posedge bus_clk);
    #1;
    arst_n = 1'b1;
    reset_test();
    release_test();
    cpu_test();
    amen_test();
    kernel_test();
    testmode_test();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== test/rcc_per_chk.sv ====
// Reset and gating checks

`timescale 1ns/1ps

module rcc_per_chk (
  input logic                            bus_clk,
  input logic                            testmode,
  input logic                            per_rst_n,
  input logic                            per_bus_clk,
  input logic [rcc_pkg::KER_SRC_NUM-1:0] per_ker_clks,
  input logic                            csi_req,
  input logic                            ker_req,
  input logic                            arcg_clk_en
);

  // gated clocks stay quiet in functional reset
  // sampled at the end of the bus clock high phase
  a_clk_low_in_reset : assert property (@(negedge bus_clk)
    (!testmode && !per_rst_n) |-> (!per_bus_clk && per_ker_clks == '0))
    else $error("gated clock active while peripheral reset is low");

  // csi request is only ever raised by the peripheral
  a_csi_needs_req : assert property (@(posedge bus_clk)
    $rose(csi_req) |-> ker_req)
    else $error("csi request rose without ker_req");

  // hold-off has run for the full delay before the gate opens
  a_release_delay : assert property (@(posedge bus_clk)
    arcg_clk_en |-> (per_rst_n && $past(per_rst_n, rcc_pkg::ARCG_DELAY)))
    else $error("clock enable high too soon after reset release");

endmodule

bind per_ker_clk_rst_control rcc_per_chk i_chk (
  .bus_clk      (bus_clk),
  .testmode     (testmode),
  .per_rst_n    (per_rst_n),
  .per_bus_clk  (per_bus_clk),
  .per_ker_clks (per_ker_clks),
  .csi_req      (csi_req),
  .ker_req      (ker_req),
  .arcg_clk_en  (arcg_clk_en)
);

// ==== hw/rcc_per_subsystem.sv ====
// RCC peripheral clock and reset subsystem

`timescale 1ns/1ps

module rcc_per_subsystem (
  // clocks
  input  logic                             bus_clk,
  input  logic [rcc_pkg::KER_SRC_NUM-1:0]  ker_src_clks,
  // resets
  input  logic                             arst_n,
  input  logic                             d1_rst_n,
  input  logic                             d2_rst_n,
  input  logic                             uart_sft_rst_n,
  input  logic                             spi_sft_rst_n,
  input  logic                             lptim_sft_rst_n,
  // cpu enables
  input  logic                             uart_c1_en,
  input  logic                             uart_c1_lpen,
  input  logic                             uart_c2_en,
  input  logic                             uart_c2_lpen,
  input  logic                             spi_c1_en,
  input  logic                             spi_c1_lpen,
  input  logic                             spi_c2_en,
  input  logic                             spi_c2_lpen,
  input  logic                             lptim_c1_en,
  input  logic                             lptim_c1_lpen,
  input  logic                             lptim_c2_en,
  input  logic                             lptim_c2_lpen,
  input  logic                             lptim_amen,
  // kernel selects and requests
  input  logic [rcc_pkg::KER_SEL_W-1:0]    uart_ker_sel,
  input  logic                             uart_ker_req,
  input  logic [rcc_pkg::KER_SEL_W-1:0]    spi_ker_sel,
  input  logic                             spi_ker_req,
  input  logic [rcc_pkg::KER_SEL_W-1:0]    lptim_ker_sel,
  input  logic                             lptim_ker_req,
  // power states
  input  logic                             c1_sleep,
  input  logic                             c1_deepsleep,
  input  logic                             c2_sleep,
  input  logic                             c2_deepsleep,
  input  logic                             d3_deepsleep,
  // test and gating control
  input  logic                             arcg_on,
  input  logic                             testmode,
  input  logic                             test_rst_n,
  // uart outputs
  output logic                             uart_bus_clk,
  output logic [rcc_pkg::KER_SRC_NUM-1:0]  uart_ker_clks,
  output logic                             uart_rst_n,
  output logic                             uart_csi_req,
  output logic                             uart_hsi_req,
  // spi outputs
  output logic                             spi_bus_clk,
  output logic [rcc_pkg::KER_SRC_NUM-1:0]  spi_ker_clks,
  output logic                             spi_rst_n,
  output logic                             spi_csi_req,
  output logic                             spi_hsi_req,
  // lptim outputs
  output logic                             lptim_bus_clk,
  output logic [rcc_pkg::KER_SRC_NUM-1:0]  lptim_ker_clks,
  output logic                             lptim_rst_n,
  output logic                             lptim_csi_req,
  output logic                             lptim_hsi_req
);

  // ==========================================================================
  // uart in D1, cpu1 owned, low power enable
  // ==========================================================================

  per_ker_clk_rst_control #(
    .DOMAIN        (rcc_pkg::DOMAIN_D1),
    .SUPPORT_LPEN  (1'b1),
    .OWNED_BY_CPU1 (1'b1),
    .HAS_CSI       (1'b1),
    .HAS_HSI       (1'b1)
  ) u_uart_d1 (
    .bus_clk      (bus_clk),
    .ker_src_clks (ker_src_clks),
    .ker_sel      (uart_ker_sel),
    .c1_en        (uart_c1_en),
    .c1_lpen      (uart_c1_lpen),
    .c2_en        (uart_c2_en),
    .c2_lpen      (uart_c2_lpen),
    .amen         (1'b0),
    .c1_sleep     (c1_sleep),
    .c1_deepsleep (c1_deepsleep),
    .c2_sleep     (c2_sleep),
    .c2_deepsleep (c2_deepsleep),
    .d3_deepsleep (d3_deepsleep),
    .ker_req      (uart_ker_req),
    .arcg_on      (arcg_on),
    .testmode     (testmode),
    .test_rst_n   (test_rst_n),
    .arst_n       (arst_n),
    .dom_rst_n    (d1_rst_n),
    .sft_rst_n    (uart_sft_rst_n),
    .per_bus_clk  (uart_bus_clk),
    .per_ker_clks (uart_ker_clks),
    .per_rst_n    (uart_rst_n),
    .csi_req      (uart_csi_req),
    .hsi_req      (uart_hsi_req)
  );

  // ==========================================================================
  // spi in D2, shared by both cpus
  // ==========================================================================

  per_ker_clk_rst_control #(
    .DOMAIN  (rcc_pkg::DOMAIN_D2),
    .HAS_CSI (1'b1),
    .HAS_HSI (1'b1)
  ) u_spi_d2 (
    .bus_clk      (bus_clk),
    .ker_src_clks (ker_src_clks),
    .ker_sel      (spi_ker_sel),
    .c1_en        (spi_c1_en),
    .c1_lpen      (spi_c1_lpen),
    .c2_en        (spi_c2_en),
    .c2_lpen      (spi_c2_lpen),
    .amen         (1'b0),
    .c1_sleep     (c1_sleep),
    .c1_deepsleep (c1_deepsleep),
    .c2_sleep     (c2_sleep),
    .c2_deepsleep (c2_deepsleep),
    .d3_deepsleep (d3_deepsleep),
    .ker_req      (spi_ker_req),
    .arcg_on      (arcg_on),
    .testmode     (testmode),
    .test_rst_n   (test_rst_n),
    .arst_n       (arst_n),
    .dom_rst_n    (d2_rst_n),
    .sft_rst_n    (spi_sft_rst_n),
    .per_bus_clk  (spi_bus_clk),
    .per_ker_clks (spi_ker_clks),
    .per_rst_n    (spi_rst_n),
    .csi_req      (spi_csi_req),
    .hsi_req      (spi_hsi_req)
  );

  // ==========================================================================
  // lptim in D3, autonomous mode, low speed sources
  // ==========================================================================

  // no domain reset above D3
  per_ker_clk_rst_control #(
    .DOMAIN       (rcc_pkg::DOMAIN_D3),
    .SUPPORT_AMEN (1'b1),
    .HAS_LSE      (1'b1),
    .HAS_LSI      (1'b1)
  ) u_lptim_d3 (
    .bus_clk      (bus_clk),
    .ker_src_clks (ker_src_clks),
    .ker_sel      (lptim_ker_sel),
    .c1_en        (lptim_c1_en),
    .c1_lpen      (lptim_c1_lpen),
    .c2_en        (lptim_c2_en),
    .c2_lpen      (lptim_c2_lpen),
    .amen         (lptim_amen),
    .c1_sleep     (c1_sleep),
    .c1_deepsleep (c1_deepsleep),
    .c2_sleep     (c2_sleep),
    .c2_deepsleep (c2_deepsleep),
    .d3_deepsleep (d3_deepsleep),
    .ker_req      (lptim_ker_req),
    .arcg_on      (arcg_on),
    .testmode     (testmode),
    .test_rst_n   (test_rst_n),
    .arst_n       (arst_n),
    .dom_rst_n    (1'b1),
    .sft_rst_n    (lptim_sft_rst_n),
    .per_bus_clk  (lptim_bus_clk),
    .per_ker_clks (lptim_ker_clks),
    .per_rst_n    (lptim_rst_n),
    .csi_req      (lptim_csi_req),
    .hsi_req      (lptim_hsi_req)
  );

endmodule

// ==== hw/per_ker_clk_rst_control.sv ====
// Peripheral bus and kernel clock and reset control

`timescale 1ns/1ps

module per_ker_clk_rst_control #(
  parameter int DOMAIN        = rcc_pkg::DOMAIN_D1,
  parameter bit SUPPORT_LPEN  = 1'b0,
  parameter bit SUPPORT_AMEN  = 1'b0,
  parameter bit OWNED_BY_CPU1 = 1'b0,
  parameter bit OWNED_BY_CPU2 = 1'b0,
  parameter bit HAS_LSE       = 1'b0,
  parameter bit HAS_LSI       = 1'b0,
  parameter bit HAS_CSI       = 1'b0,
  parameter bit HAS_HSI       = 1'b0
) (
  input  logic                             bus_clk,
  input  logic [rcc_pkg::KER_SRC_NUM-1:0]  ker_src_clks,
  input  logic [rcc_pkg::KER_SEL_W-1:0]    ker_sel,
  input  logic                             c1_en,
  input  logic                             c1_lpen,
  input  logic                             c2_en,
  input  logic                             c2_lpen,
  input  logic                             amen,
  input  logic                             c1_sleep,
  input  logic                             c1_deepsleep,
  input  logic                             c2_sleep,
  input  logic                             c2_deepsleep,
  input  logic                             d3_deepsleep,
  input  logic                             ker_req,
  input  logic                             arcg_on,
  input  logic                             testmode,
  input  logic                             test_rst_n,
  input  logic                             arst_n,
  input  logic                             dom_rst_n,
  input  logic                             sft_rst_n,
  output logic                             per_bus_clk,
  output logic [rcc_pkg::KER_SRC_NUM-1:0]  per_ker_clks,
  output logic                             per_rst_n,
  output logic                             csi_req,
  output logic                             hsi_req
);

  logic c1_lp_ok;
  logic c2_lp_ok;
  logic c1_term;
  logic c2_term;
  logic d3_term;
  logic arcg_clk_en;
  logic bus_clk_en;
  logic ker_clk_en;
  logic lse_req;
  logic lsi_req;
  logic func_rst_n;

  // ==========================================================================
  // cpu and domain enable terms
  // ==========================================================================

  // sleep only stops the clock when the lpen bit is clear
  if (SUPPORT_LPEN) begin : g_lpen
    assign c1_lp_ok = ~c1_sleep | c1_lpen;
    assign c2_lp_ok = ~c2_sleep | c2_lpen;
  end else begin : g_no_lpen
    assign c1_lp_ok = 1'b1;
    assign c2_lp_ok = 1'b1;
  end

  // an owning cpu always has the peripheral enabled
  if (OWNED_BY_CPU1) begin : g_cpu1_owner
    assign c1_term = c1_lp_ok & ~c1_deepsleep;
  end else begin : g_cpu1_shared
    assign c1_term = c1_en & c1_lp_ok & ~c1_deepsleep;
  end

  if (OWNED_BY_CPU2) begin : g_cpu2_owner
    assign c2_term = c2_lp_ok & ~c2_deepsleep;
  end else begin : g_cpu2_shared
    assign c2_term = c2_en & c2_lp_ok & ~c2_deepsleep;
  end

  // autonomous mode keeps a D3 peripheral running with both cpus off
  if (DOMAIN == rcc_pkg::DOMAIN_D3) begin : g_d3
    if (SUPPORT_AMEN) begin : g_amen
      assign d3_term = amen & ~d3_deepsleep;
    end else begin : g_no_amen
      assign d3_term = ~d3_deepsleep;
    end
  end else begin : g_d1_d2
    assign d3_term = 1'b0;
  end

  // ==========================================================================
  // bus clock
  // ==========================================================================

  // hold-off counter runs on the peripheral reset
  sync_reset_clk_gate u_sync_reset_clk_gate (
    .bus_clk (bus_clk),
    .arst_n  (per_rst_n),
    .arcg_on (arcg_on),
    .clk_en  (arcg_clk_en)
  );

  assign bus_clk_en = (c1_term | c2_term | d3_term) & arcg_clk_en;

  clk_gate_cell u_bus_gate (
    .raw_clk (bus_clk),
    .active  (bus_clk_en),
    .bypass  (testmode),
    .arst_n  (per_rst_n),
    .gen_clk (per_bus_clk)
  );

  // ==========================================================================
  // kernel clock requests
  // ==========================================================================

  // low speed sources run on selection alone
  assign lse_req = HAS_LSE & (ker_sel == rcc_pkg::LSE_IDX);
  assign lsi_req = HAS_LSI & (ker_sel == rcc_pkg::LSI_IDX);

  // oscillators that can be stopped need the peripheral to ask
  assign csi_req = HAS_CSI & (ker_sel == rcc_pkg::CSI_IDX) & ker_req;
  assign hsi_req = HAS_HSI & (ker_sel == rcc_pkg::HSI_IDX) & ker_req;

  assign ker_clk_en = (bus_clk_en | lse_req | lsi_req | csi_req | hsi_req) & arcg_clk_en;

  // one gate per source, each latched on its own clock
  for (genvar i = 0; i < rcc_pkg::KER_SRC_NUM; i++) begin : g_ker_gate
    clk_gate_cell u_ker_gate (
      .raw_clk (ker_src_clks[i]),
      .active  (ker_clk_en),
      .bypass  (testmode),
      .arst_n  (per_rst_n),
      .gen_clk (per_ker_clks[i])
    );
  end

  // ==========================================================================
  // peripheral reset
  // ==========================================================================

  // D3 sits outside the D1 and D2 reset trees
  if (DOMAIN == rcc_pkg::DOMAIN_D3) begin : g_d3_rst
    assign func_rst_n = arst_n & sft_rst_n;
  end else begin : g_dom_rst
    assign func_rst_n = arst_n & dom_rst_n & sft_rst_n;
  end

  // test reset mux
  assign per_rst_n = testmode ? test_rst_n : func_rst_n;

endmodule

// ==== hw/sync_reset_clk_gate.sv ====
// Clock hold-off after reset release

`timescale 1ns/1ps

module sync_reset_clk_gate #(
  parameter int DELAY = rcc_pkg::ARCG_DELAY
) (
  input  logic bus_clk,
  input  logic arst_n,
  input  logic arcg_on,
  output logic clk_en
);

  // at least one bit even for a zero delay
  localparam int CNT_W = (DELAY > 0) ? $clog2(DELAY + 1) : 1;
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DELAY);

  // rising edges seen since per_rst_n went high
  logic [CNT_W-1:0] edge_cnt;
  logic             cnt_done;

  // ==========================================================================
  // release counter
  // ==========================================================================

  assign cnt_done = (edge_cnt == CNT_MAX);

  // counts once per bus clock and parks at DELAY
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      edge_cnt <= '0;
    end else if (!cnt_done) begin
      edge_cnt <= edge_cnt + 1'b1;
    end
  end

  // ==========================================================================
  // gate enable
  // ==========================================================================

  // changes right after a rising edge, so the gate latch picks it up
  // in the following low phase and the first pulse lands on edge DELAY+1
  assign clk_en = cnt_done & arcg_on;

endmodule

// ==== hw/clk_gate_cell.sv ====
// Latch based clock gate

`timescale 1ns/1ps

module clk_gate_cell (
  input  logic raw_clk,
  input  logic active,
  input  logic bypass,
  input  logic arst_n,
  output logic gen_clk
);

  // enable as seen during the last low phase of raw_clk
  logic en_latch;

  // ==========================================================================
  // enable latch
  // ==========================================================================

  // open while raw_clk is low so the enable only changes between pulses
  always_latch begin
    if (!arst_n) begin
      en_latch <= 1'b0;
    end else if (!raw_clk) begin
      en_latch <= active;
    end
  end

  // ==========================================================================
  // gated output
  // ==========================================================================

  // test bypass passes the raw clock straight through
  assign gen_clk = raw_clk & (en_latch | bypass);

endmodule

// ==== hw/rcc_pkg.sv ====
// RCC peripheral slice definitions

package rcc_pkg;

  // ==========================================================================
  // kernel clock sources
  // ==========================================================================

  // width of the kernel clock select field
  localparam int KER_SEL_W = 2;

  // one source clock per select code
  localparam int KER_SRC_NUM = 4;

  // select codes, also the bit index into ker_src_clks
  localparam logic [KER_SEL_W-1:0] HSI_IDX = 2'd0;
  localparam logic [KER_SEL_W-1:0] CSI_IDX = 2'd1;
  localparam logic [KER_SEL_W-1:0] LSE_IDX = 2'd2;
  localparam logic [KER_SEL_W-1:0] LSI_IDX = 2'd3;

  // ==========================================================================
  // power domains
  // ==========================================================================

  // D1 and D2 take a domain reset, D3 does not
  localparam int DOMAIN_D1 = 1;
  localparam int DOMAIN_D2 = 2;
  localparam int DOMAIN_D3 = 3;

  // ==========================================================================
  // reset release
  // ==========================================================================

  // bus clock rising edges with clocks held off after per_rst_n rises
  localparam int ARCG_DELAY = 2;

endpackage
